/* Bender.yml */
package:
  name: ptw_sv39

sources:
  - ptw_pkg.sv
  - ptw_req_capture.sv
  - ptw_pte_check.sv
  - ptw_walk_fsm.sv
  - ptw_result.sv
  - ptw_top.sv
  - target: test
    files:
      - tb_ptw.sv

/* filelist.f */
ptw_pkg.sv
ptw_req_capture.sv
ptw_pte_check.sv
ptw_walk_fsm.sv
ptw_result.sv
ptw_top.sv
tb_ptw.sv

/* ptw_pkg.sv */
/*
 * Shared definitions of the Sv39 page table walker
 * Address, page number and ID widths
 * Sv39 PTE layout
 * Level, walker state, fault kind and cause encodings
 */
`default_nettype none

package ptw_pkg;

    // Sv39 IOVA and physical address widths
    localparam int unsigned IOVA_W  = 39;
    localparam int unsigned PLEN    = 56;
    localparam int unsigned PPN_W   = 44;
    // VPN[2:0] together, as stored in the IOTLB
    localparam int unsigned VPN_W   = 27;
    localparam int unsigned PSCID_W = 20;
    localparam int unsigned CAUSE_W = 11;

    // One 64-bit Sv39 PTE, MSB first
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // Walk level, LVL1 reads the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    // Walker FSM
    typedef enum logic [1:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT,
        DONE
    } walk_state_e;

    // IOMMU fault causes
    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_NONE         = 11'd0,
        LOAD_PAGE_FAULT    = 11'd13,
        STORE_PAGE_FAULT   = 11'd15,
        PT_DATA_CORRUPTION = 11'd274
    } cause_e;

    // Outcome of one PTE read
    typedef enum logic [1:0] {
        F_NONE,
        F_PAGE,
        F_BUS
    } fault_e;

endpackage

`default_nettype wire

/* ptw_pte_check.sv */
/*
 * Sv39 PTE classification
 * Leaf detection, page fault rules, next table pointer
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_pte_check import ptw_pkg::*; (
    input  wire pte_t          pte_i,
    input  wire level_e        level_i,
    input  wire [IOVA_W-1:0]   iova_i,
    input  wire                is_store_i,
    output logic               is_leaf_o,
    output logic               page_fault_o,
    output logic [PLEN-1:0]    next_ptr_o
);

    logic       invalid;
    logic       rsvd_set;
    logic       misaligned;
    logic       leaf_bad;
    logic       nonleaf_bad;
    logic [8:0] vpn_seg;

    // R or X marks a leaf
    assign is_leaf_o = pte_i.r || pte_i.x;

    // V clear, or W without R
    assign invalid  = !pte_i.v || (!pte_i.r && pte_i.w);
    assign rsvd_set = |pte_i.reserved;

    // Superpage PPN must be aligned to its size
    always_comb begin
        case (level_i)
            LVL1:    misaligned = |pte_i.ppn[17:0];
            LVL2:    misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Leaf needs A and R, and D for a store
    assign leaf_bad = misaligned || !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    // Pointer PTE: A, D, U reserved, none allowed at the last level
    assign nonleaf_bad = pte_i.a || pte_i.d || pte_i.u || (level_i == LVL3);

    assign page_fault_o = invalid || rsvd_set ||
                          (is_leaf_o ? leaf_bad : nonleaf_bad);

    // VPN[1] indexes level 2, VPN[0] indexes level 3
    always_comb begin
        case (level_i)
            LVL1:    vpn_seg = iova_i[29:21];
            default: vpn_seg = iova_i[20:12];
        endcase
    end

    assign next_ptr_o = {pte_i.ppn, vpn_seg, 3'b000};

endmodule

`default_nettype wire

/* ptw_req_capture.sv */
/*
 * Request capture of the page table walker
 * Start edge detection, request registers, level-1 pointer
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_req_capture import ptw_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                start_i,
    input  wire                busy_i,
    input  wire [IOVA_W-1:0]   iova_i,
    input  wire [PSCID_W-1:0]  pscid_i,
    input  wire                is_store_i,
    input  wire [PPN_W-1:0]    root_ppn_i,
    output logic               walk_start_o,
    output logic [IOVA_W-1:0]  iova_o,
    output logic [PSCID_W-1:0] pscid_o,
    output logic               is_store_o,
    output logic [PLEN-1:0]    first_ptr_o
);

    logic start_q;
    logic accept;

    // Rising edge on start, only while no walk runs
    assign accept = start_i && !start_q && !busy_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_q      <= 1'b0;
            walk_start_o <= 1'b0;
        end else begin
            // Edge seen during a walk is consumed here too
            start_q      <= start_i;
            walk_start_o <= accept;
        end
    end

    // Request held for the whole walk
    always_ff @(posedge clk_i) begin
        if (accept) begin
            iova_o      <= iova_i;
            pscid_o     <= pscid_i;
            is_store_o  <= is_store_i;
            // Root table base plus VPN[2], 8-byte entries
            first_ptr_o <= {root_ppn_i, iova_i[38:30], 3'b000};
        end
    end

    // Walker turns busy right after a start, so no second start overlaps
    a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_start_o |=> busy_i);

endmodule

`default_nettype wire

/* ptw_result.sv */
/*
 * Walk result
 * Global bit accumulation, IOTLB update pulse, error pulse and cause
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_result import ptw_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                walk_start_i,
    input  wire                rd_valid_i,
    input  wire pte_t          rd_data_i,
    input  wire                walk_end_i,
    input  wire fault_e        end_fault_i,
    input  wire level_e        end_level_i,
    input  wire pte_t          end_pte_i,
    input  wire [IOVA_W-1:0]   iova_i,
    input  wire [PSCID_W-1:0]  pscid_i,
    input  wire                is_store_i,
    output logic               update_o,
    output logic [VPN_W-1:0]   up_vpn_o,
    output logic [PSCID_W-1:0] up_pscid_o,
    output pte_t               up_pte_o,
    output logic               up_2m_o,
    output logic               up_1g_o,
    output logic               error_o,
    output cause_e             cause_o
);

    logic   g_q;
    pte_t   leaf_pte;
    cause_e cause;

    // Leaf is global if any PTE on the walk was
    always_comb begin
        leaf_pte   = end_pte_i;
        leaf_pte.g = g_q || end_pte_i.g;
    end

    always_comb begin
        case (end_fault_i)
            F_BUS:   cause = PT_DATA_CORRUPTION;
            F_PAGE:  cause = is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
            default: cause = CAUSE_NONE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            g_q      <= 1'b0;
            update_o <= 1'b0;
            error_o  <= 1'b0;
        end else begin
            update_o <= walk_end_i && (end_fault_i == F_NONE);
            error_o  <= walk_end_i && (end_fault_i != F_NONE);
            if (walk_start_i) begin
                g_q <= 1'b0;
            end else if (rd_valid_i && rd_data_i.g) begin
                g_q <= 1'b1;
            end
        end
    end

    // Payload valid with the pulse
    always_ff @(posedge clk_i) begin
        if (walk_end_i) begin
            up_vpn_o   <= iova_i[IOVA_W-1:12];
            up_pscid_o <= pscid_i;
            up_pte_o   <= leaf_pte;
            up_2m_o    <= (end_level_i == LVL2);
            up_1g_o    <= (end_level_i == LVL1);
            cause_o    <= cause;
        end
    end

    // One result pulse per walk end, one cycle wide
    a_one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (update_o || error_o) |=> !(update_o || error_o));

endmodule

`default_nettype wire

/* ptw_top.sv */
/*
 * Sv39 page table walker top level
 * Request capture, walk FSM and result blocks
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_top import ptw_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                start_i,
    input  wire [IOVA_W-1:0]   iova_i,
    input  wire [PSCID_W-1:0]  pscid_i,
    input  wire                is_store_i,
    input  wire [PPN_W-1:0]    root_ppn_i,
    input  wire                rd_valid_i,
    input  wire pte_t          rd_data_i,
    input  wire                rd_err_i,
    output logic               rd_req_o,
    output logic [PLEN-1:0]    rd_addr_o,
    output logic               busy_o,
    output logic               update_o,
    output logic [VPN_W-1:0]   up_vpn_o,
    output logic [PSCID_W-1:0] up_pscid_o,
    output pte_t               up_pte_o,
    output logic               up_2m_o,
    output logic               up_1g_o,
    output logic               error_o,
    output cause_e             cause_o
);

    logic               walk_start;
    logic [PLEN-1:0]    first_ptr;
    logic [IOVA_W-1:0]  iova;
    logic [PSCID_W-1:0] pscid;
    logic               is_store;
    logic               walk_end;
    fault_e             end_fault;
    level_e             end_level;
    pte_t               end_pte;

    ptw_req_capture u_req_capture (
        .clk_i, .rst_ni, .start_i,
        .busy_i       (busy_o),
        .iova_i, .pscid_i, .is_store_i, .root_ppn_i,
        .walk_start_o (walk_start),
        .iova_o       (iova),
        .pscid_o      (pscid),
        .is_store_o   (is_store),
        .first_ptr_o  (first_ptr)
    );

    ptw_walk_fsm u_walk_fsm (
        .clk_i, .rst_ni,
        .walk_start_i (walk_start),
        .first_ptr_i  (first_ptr),
        .iova_i       (iova),
        .is_store_i   (is_store),
        .rd_valid_i, .rd_data_i, .rd_err_i,
        .rd_req_o, .rd_addr_o, .busy_o,
        .walk_end_o   (walk_end),
        .end_fault_o  (end_fault),
        .end_level_o  (end_level),
        .end_pte_o    (end_pte)
    );

    ptw_result u_result (
        .clk_i, .rst_ni,
        .walk_start_i (walk_start),
        .rd_valid_i, .rd_data_i,
        .walk_end_i   (walk_end),
        .end_fault_i  (end_fault),
        .end_level_i  (end_level),
        .end_pte_i    (end_pte),
        .iova_i       (iova),
        .pscid_i      (pscid),
        .is_store_i   (is_store),
        .update_o, .up_vpn_o, .up_pscid_o, .up_pte_o,
        .up_2m_o, .up_1g_o, .error_o, .cause_o
    );

endmodule

`default_nettype wire

/* ptw_walk_fsm.sv */
/*
 * Walker FSM
 * Level and read pointer tracking, read port, end-of-walk report
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_fsm import ptw_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                walk_start_i,
    input  wire [PLEN-1:0]     first_ptr_i,
    input  wire [IOVA_W-1:0]   iova_i,
    input  wire                is_store_i,
    input  wire                rd_valid_i,
    input  wire pte_t          rd_data_i,
    input  wire                rd_err_i,
    output logic               rd_req_o,
    output logic [PLEN-1:0]    rd_addr_o,
    output logic               busy_o,
    output logic               walk_end_o,
    output fault_e             end_fault_o,
    output level_e             end_level_o,
    output pte_t               end_pte_o
);

    walk_state_e     state_q, state_d;
    level_e          level_q, level_d;
    logic [PLEN-1:0] ptr_q, ptr_d;
    logic            is_leaf;
    logic            page_fault;
    logic [PLEN-1:0] next_ptr;
    logic            resp;
    logic            advance;

    ptw_pte_check u_pte_check (
        .pte_i        (rd_data_i),
        .level_i      (level_q),
        .iova_i       (iova_i),
        .is_store_i   (is_store_i),
        .is_leaf_o    (is_leaf),
        .page_fault_o (page_fault),
        .next_ptr_o   (next_ptr)
    );

    assign resp = (state_q == MEM_WAIT) && rd_valid_i;
    // Only a clean pointer PTE continues the walk
    assign advance = resp && !rd_err_i && !page_fault && !is_leaf;

    // Read strobe for one cycle per level
    assign rd_req_o  = (state_q == MEM_REQ);
    assign rd_addr_o = ptr_q;
    // Busy already in the walk_start cycle
    assign busy_o    = (state_q != IDLE) || walk_start_i;

    // End report on the response cycle
    assign walk_end_o  = resp && !advance;
    assign end_level_o = level_q;
    assign end_pte_o   = rd_data_i;

    // Bus error ranks above any page fault
    always_comb begin
        if (rd_err_i) begin
            end_fault_o = F_BUS;
        end else if (page_fault) begin
            end_fault_o = F_PAGE;
        end else begin
            end_fault_o = F_NONE;
        end
    end

    always_comb begin
        state_d = state_q;
        level_d = level_q;
        ptr_d   = ptr_q;
        case (state_q)
            IDLE: begin
                if (walk_start_i) begin
                    state_d = MEM_REQ;
                    level_d = LVL1;
                    ptr_d   = first_ptr_i;
                end
            end
            MEM_REQ: state_d = MEM_WAIT;
            MEM_WAIT: begin
                if (advance) begin
                    state_d = MEM_REQ;
                    level_d = (level_q == LVL1) ? LVL2 : LVL3;
                    ptr_d   = next_ptr;
                end else if (resp) begin
                    // Result side pulses update or error in DONE
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= LVL1;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
            ptr_q   <= ptr_d;
        end
    end

    // Memory answers only an outstanding read
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_valid_i |-> (state_q == MEM_WAIT));

    a_req_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_req_o |=> !rd_req_o);

endmodule

`default_nettype wire

/* tb_ptw.sv */
/*
 * Testbench of the Sv39 page table walker
 * Clock, reset, PTE memory model with random latency
 * Walk table of page sizes, faults and bus errors
 * Compare tasks and cycle timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ptw import ptw_pkg::*; ();

    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned ROW_CYCLES   = 20;
    // VPN[2] = 5, VPN[1] = 17, VPN[0] = 300
    localparam logic [IOVA_W-1:0]  VA       = {9'd5, 9'd17, 9'd300, 12'h000};
    localparam logic [PSCID_W-1:0] PSCID    = 20'hABCDE;
    localparam logic [PPN_W-1:0]   ROOT     = 44'h100;
    localparam logic [PPN_W-1:0]   P1       = 44'h200;
    localparam logic [PPN_W-1:0]   P2       = 44'h300;
    localparam logic [PPN_W-1:0]   LEAF_PPN = 44'h12345;
    // Flag bytes as {d, a, g, u, x, w, r, v}
    localparam logic [7:0] PTR     = 8'h01;
    localparam logic [7:0] PTR_G   = 8'h21;
    localparam logic [7:0] RWXAD   = 8'hCF;
    localparam logic [7:0] RWXAD_G = 8'hEF;

    typedef struct {
        string  name;
        logic   store;
        int     n_pte;
        pte_t   pte [3];
        int     err_lvl;
        cause_e exp_cause;
        logic   exp_2m;
        logic   exp_1g;
        pte_t   exp_pte;
    } walk_row_t;

    logic               clk_i;
    logic               rst_ni;
    logic               start_i;
    logic [IOVA_W-1:0]  iova_i;
    logic [PSCID_W-1:0] pscid_i;
    logic               is_store_i;
    logic [PPN_W-1:0]   root_ppn_i;
    logic               rd_valid_i;
    pte_t               rd_data_i;
    logic               rd_err_i;
    logic               rd_req_o;
    logic [PLEN-1:0]    rd_addr_o;
    logic               busy_o;
    logic               update_o;
    logic [VPN_W-1:0]   up_vpn_o;
    logic [PSCID_W-1:0] up_pscid_o;
    pte_t               up_pte_o;
    logic               up_2m_o;
    logic               up_1g_o;
    logic               error_o;
    cause_e             cause_o;

    walk_row_t   rows [$];
    pte_t        mem [logic [PLEN-1:0]];
    logic        err_at [logic [PLEN-1:0]];
    int unsigned cycles;
    int unsigned cycle_limit;

    ptw_top dut0 (
        .clk_i, .rst_ni, .start_i, .iova_i, .pscid_i, .is_store_i, .root_ppn_i,
        .rd_valid_i, .rd_data_i, .rd_err_i, .rd_req_o, .rd_addr_o, .busy_o,
        .update_o, .up_vpn_o, .up_pscid_o, .up_pte_o, .up_2m_o, .up_1g_o,
        .error_o, .cause_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cause(input string name, input cause_e exp, input cause_e act);
        if (exp !== act) begin
            $display("CHECK FAILED %s cause: expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pte(input string name, input pte_t exp, input pte_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s pte: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Flags, PSCID and VPN, zero extended
    task automatic check_bits(input string name, input string what,
                              input logic [VPN_W-1:0] exp, input logic [VPN_W-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h", name, what, exp, act);
            abort_run();
        end
    endtask

    function automatic pte_t make_pte(input logic [PPN_W-1:0] ppn, input logic [7:0] flags);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // Table base, then VPN segment of the level, 8-byte entries
    function automatic logic [PLEN-1:0] entry_addr(input logic [PPN_W-1:0] base,
                                                   input logic [IOVA_W-1:0] va, input int lvl);
        logic [8:0] seg;
        seg = (lvl == 0) ? va[38:30] : (lvl == 1) ? va[29:21] : va[20:12];
        return {base, seg, 3'b000};
    endfunction

    task automatic add_row(input string name, input logic store, input int n,
                           input pte_t p0, input pte_t p1, input pte_t p2, input int err_lvl,
                           input cause_e cause, input logic s2m, input logic s1g,
                           input pte_t exp_pte);
        walk_row_t r;
        r.name      = name;
        r.store     = store;
        r.n_pte     = n;
        r.pte[0]    = p0;
        r.pte[1]    = p1;
        r.pte[2]    = p2;
        r.err_lvl   = err_lvl;
        r.exp_cause = cause;
        r.exp_2m    = s2m;
        r.exp_1g    = s1g;
        r.exp_pte   = exp_pte;
        rows.push_back(r);
    endtask

    task automatic build_table();
        pte_t z;
        pte_t ptr1;
        pte_t ptr2;
        pte_t leaf;
        pte_t p1g;
        pte_t p2m;
        pte_t rsvd;
        z    = '0;
        ptr1 = make_pte(P1, PTR);
        ptr2 = make_pte(P2, PTR);
        leaf = make_pte(LEAF_PPN, RWXAD);
        p1g  = make_pte(44'h40000, RWXAD);
        p2m  = make_pte(44'h200, RWXAD);
        rsvd = p2m;
        rsvd.reserved = 10'h200;
        // Good walks of each page size
        add_row("walk_4k", 0, 3, ptr1, ptr2, leaf, 0, CAUSE_NONE, 0, 0, leaf);
        add_row("leaf_1g", 0, 1, p1g, z, z, 0, CAUSE_NONE, 0, 1, p1g);
        add_row("leaf_2m", 1, 2, ptr1, p2m, z, 0, CAUSE_NONE, 1, 0, p2m);
        // G only in the root pointer still marks the leaf global
        add_row("global_ptr", 0, 3, make_pte(P1, PTR_G), ptr2, leaf, 0, CAUSE_NONE, 0, 0,
                make_pte(LEAF_PPN, RWXAD_G));
        // Page fault rules
        add_row("invalid", 0, 1, z, z, z, 0, LOAD_PAGE_FAULT, 0, 0, z);
        add_row("reserved", 1, 2, ptr1, rsvd, z, 0, STORE_PAGE_FAULT, 0, 0, z);
        add_row("misaligned_1g", 0, 1, make_pte(44'h1, RWXAD), z, z, 0, LOAD_PAGE_FAULT,
                0, 0, z);
        add_row("misaligned_2m", 1, 2, ptr1, make_pte(44'h100, RWXAD), z, 0,
                STORE_PAGE_FAULT, 0, 0, z);
        add_row("leaf_no_a", 0, 3, ptr1, ptr2, make_pte(LEAF_PPN, 8'h8F), 0,
                LOAD_PAGE_FAULT, 0, 0, z);
        add_row("leaf_no_r", 0, 2, ptr1, make_pte(44'h200, 8'hC9), z, 0, LOAD_PAGE_FAULT,
                0, 0, z);
        add_row("store_no_d", 1, 3, ptr1, ptr2, make_pte(LEAF_PPN, 8'h4F), 0,
                STORE_PAGE_FAULT, 0, 0, z);
        add_row("ptr_a", 0, 1, make_pte(P1, 8'h41), z, z, 0, LOAD_PAGE_FAULT, 0, 0, z);
        add_row("ptr_d", 1, 2, ptr1, make_pte(P2, 8'h81), z, 0, STORE_PAGE_FAULT, 0, 0, z);
        add_row("ptr_u", 0, 1, make_pte(P1, 8'h11), z, z, 0, LOAD_PAGE_FAULT, 0, 0, z);
        add_row("ptr_lvl3", 1, 3, ptr1, ptr2, ptr2, 0, STORE_PAGE_FAULT, 0, 0, z);
        // Bus error beats the invalid PTE it comes with
        add_row("bus_err", 0, 2, ptr1, z, z, 2, PT_DATA_CORRUPTION, 0, 0, z);
        add_row("bus_err_leaf", 1, 1, p1g, z, z, 1, PT_DATA_CORRUPTION, 0, 0, z);
    endtask

    // One walk, start held high for a while when hold is set
    task automatic run_walk(input walk_row_t row, input bit hold);
        logic [PPN_W-1:0] base;
        logic [PLEN-1:0]  addr;
        int               extra;
        mem.delete();
        err_at.delete();
        base  = ROOT;
        extra = 0;
        for (int lvl = 0; lvl < row.n_pte; lvl++) begin
            addr         = entry_addr(base, VA, lvl);
            mem[addr]    = row.pte[lvl];
            err_at[addr] = (row.err_lvl == lvl + 1);
            base         = row.pte[lvl].ppn;
        end
        @(posedge clk_i);
        #10;
        iova_i     = VA;
        pscid_i    = PSCID;
        is_store_i = row.store;
        root_ppn_i = ROOT;
        start_i    = 1'b1;
        @(posedge clk_i);
        #10;
        if (!hold) begin
            start_i = 1'b0;
        end
        // First negedge here falls in the walk_start cycle
        @(negedge clk_i);
        while (!update_o && !error_o) begin
            check_bits(row.name, "busy_o", 1, busy_o);
            @(negedge clk_i);
        end
        check_bits(row.name, "busy_o", 1, busy_o);
        check_bits(row.name, "error_o", row.exp_cause != CAUSE_NONE, error_o);
        check_bits(row.name, "update_o", row.exp_cause == CAUSE_NONE, update_o);
        if (row.exp_cause != CAUSE_NONE) begin
            check_cause(row.name, row.exp_cause, cause_o);
        end else begin
            check_bits(row.name, "up_vpn_o", VA[38:12], up_vpn_o);
            check_bits(row.name, "up_pscid_o", PSCID, up_pscid_o);
            check_pte(row.name, row.exp_pte, up_pte_o);
            check_bits(row.name, "up_2m_o", row.exp_2m, up_2m_o);
            check_bits(row.name, "up_1g_o", row.exp_1g, up_1g_o);
        end
        @(negedge clk_i);
        check_bits(row.name, "busy_o after end", 0, busy_o);
        if (hold) begin
            // A held start must not begin a second walk
            repeat (ROW_CYCLES) begin
                @(negedge clk_i);
                if (update_o || error_o || busy_o) begin
                    extra++;
                end
            end
            check_bits(row.name, "activity with start held", 0, extra);
            @(posedge clk_i);
            #10;
            start_i = 1'b0;
        end
    endtask

    // PTE memory, one answer per read after 1 to 4 cycles
    initial begin : memory_model
        logic [PLEN-1:0] addr;
        int unsigned     delay;
        forever begin
            @(negedge clk_i);
            if (rst_ni && rd_req_o) begin
                addr = rd_addr_o;
                if (!mem.exists(addr)) begin
                    $display("Walker read address %h, which holds no PTE of this walk", addr);
                    abort_run();
                end
                delay = 1 + ($urandom % 4);
                repeat (delay) @(posedge clk_i);
                #10;
                rd_valid_i = 1'b1;
                rd_data_i  = mem[addr];
                rd_err_i   = err_at[addr];
                @(posedge clk_i);
                #10;
                rd_valid_i = 1'b0;
                rd_data_i  = '0;
                rd_err_i   = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d cycles, the walks did not finish", cycles);
                abort_run();
            end
        end
    end

    initial begin : main
        void'($urandom(91));
        rst_ni     = 1'b0;
        start_i    = 1'b0;
        iova_i     = '0;
        pscid_i    = '0;
        is_store_i = 1'b0;
        root_ppn_i = '0;
        rd_valid_i = 1'b0;
        rd_data_i  = '0;
        rd_err_i   = 1'b0;
        build_table();
        // Table rows plus the held start walk, which counts twice
        cycle_limit = (rows.size() + 2) * ROW_CYCLES + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk_i);
        check_bits("reset", "req/update/error/busy", 0,
                   {rd_req_o, update_o, error_o, busy_o});
        #10;
        rst_ni = 1'b1;
        foreach (rows[i]) begin
            run_walk(rows[i], 1'b0);
        end
        run_walk(rows[0], 1'b1);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
